//--- list.f
verilog/tag_cmp_pkg.sv
verilog/cache_req_if.sv
verilog/rmw_if.sv
verilog/secded_codec.sv
verilog/req_arbiter.sv
verilog/rmw_buffer.sv
verilog/line_merge.sv
verilog/tag_match.sv
verilog/tag_cmp_top.sv
verif/sram_model.sv
verif/tb_tag_cmp.sv

//--- verif/tb_tag_cmp.sv
// scenario table runs in order and later entries rely on lines written by earlier ones
`timescale 1ns/100ps

module tb_tag_cmp;

  typedef struct packed {
    logic [tag_cmp_pkg::NR_PORTS-1:0]   mask;
    logic [tag_cmp_pkg::NR_WAYS-1:0]    req;
    logic [tag_cmp_pkg::ADDR_WIDTH-1:0] addr;
    logic                               we;
    tag_cmp_pkg::line_t                 wdata;
    tag_cmp_pkg::be_t                   be;
    logic [tag_cmp_pkg::TAG_WIDTH-1:0]  tag;
    // 1 single data flip, 2 double data flip, 3 single tag flip, all on way 0
    logic [1:0]                         flip;
    logic [tag_cmp_pkg::NR_PORTS-1:0]   gnt;
    logic [3:0]                         cyc;
    logic [tag_cmp_pkg::NR_WAYS-1:0]    hit;
    logic [1:0]                         err;
  } test_t;

  logic                                                              clk_i;
  logic                                                              rst_ni;
  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::NR_WAYS-1:0]        req_i;
  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::ADDR_WIDTH-1:0]     addr_i;
  logic [tag_cmp_pkg::NR_PORTS-1:0]                                  we_i;
  tag_cmp_pkg::line_t [tag_cmp_pkg::NR_PORTS-1:0]                    wdata_i;
  tag_cmp_pkg::be_t [tag_cmp_pkg::NR_PORTS-1:0]                      be_i;
  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::TAG_WIDTH-1:0]      tag_i;
  logic [tag_cmp_pkg::NR_PORTS-1:0]                                  gnt_o;
  tag_cmp_pkg::line_t [tag_cmp_pkg::NR_WAYS-1:0]                     rdata_o;
  logic [tag_cmp_pkg::NR_WAYS-1:0]                                   hit_way_o;
  logic                                                              err_correctable_o;
  logic                                                              err_uncorrectable_o;
  logic [tag_cmp_pkg::NR_WAYS-1:0]                                   sram_req;
  logic [tag_cmp_pkg::ADDR_WIDTH-1:0]                                sram_addr;
  logic                                                              sram_we;
  tag_cmp_pkg::line_ecc_t                                            sram_wdata;
  tag_cmp_pkg::sram_be_t                                             sram_be;
  tag_cmp_pkg::line_ecc_t [tag_cmp_pkg::NR_WAYS-1:0]                 sram_rdata;

  test_t              tests[$];
  tag_cmp_pkg::line_t ref_mem [int];
  integer             seed;
  int                 cycles = 0;
  int                 n_pass = 0;
  int                 n_fail = 0;

  always #4 clk_i = ~clk_i;

  tag_cmp_top u_tag_cmp_top (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .addr_i              (addr_i),
    .we_i                (we_i),
    .wdata_i             (wdata_i),
    .be_i                (be_i),
    .tag_i               (tag_i),
    .gnt_o               (gnt_o),
    .rdata_o             (rdata_o),
    .hit_way_o           (hit_way_o),
    .err_correctable_o   (err_correctable_o),
    .err_uncorrectable_o (err_uncorrectable_o),
    .sram_req_o          (sram_req),
    .sram_addr_o         (sram_addr),
    .sram_we_o           (sram_we),
    .sram_wdata_o        (sram_wdata),
    .sram_be_o           (sram_be),
    .sram_rdata_i        (sram_rdata)
  );

  sram_model u_sram_model (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (sram_req),
    .addr_i  (sram_addr),
    .we_i    (sram_we),
    .wdata_i (sram_wdata),
    .be_i    (sram_be),
    .rdata_o (sram_rdata)
  );

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic tag_cmp_pkg::line_t ref_read(input int way, input int addr);
    int key;
    key = way * (2**tag_cmp_pkg::ADDR_WIDTH) + addr;
    if (ref_mem.exists(key)) return ref_mem[key];
    return '0;
  endfunction

  // enabled bytes come from the write line, the rest from the stored line
  function automatic tag_cmp_pkg::line_t merge_bytes(input tag_cmp_pkg::line_t old_line,
                                                     input tag_cmp_pkg::line_t new_line,
                                                     input tag_cmp_pkg::be_t be);
    tag_cmp_pkg::line_t res;
    res = old_line;
    if (be.valid) res.valid = new_line.valid;
    for (int i = 0; i < tag_cmp_pkg::TAG_WIDTH / 8; i++) begin
      if (be.tag[i]) res.tag[i*8 +: 8] = new_line.tag[i*8 +: 8];
    end
    for (int i = 0; i < tag_cmp_pkg::LINE_WIDTH / 8; i++) begin
      if (be.data[i]) res.data[i*8 +: 8] = new_line.data[i*8 +: 8];
    end
    return res;
  endfunction

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic add_test(input logic [1:0] mask, input logic [1:0] req, input logic [11:0] addr,
                          input logic we, input logic valid, input logic [15:0] tag,
                          input tag_cmp_pkg::be_t be, input logic [1:0] flip,
                          input logic [1:0] gnt, input logic [3:0] cyc,
                          input logic [1:0] hit, input logic [1:0] err);
    test_t t;
    t.mask = mask;
    t.req = req;
    t.addr = addr;
    t.we = we;
    t.wdata.valid = valid;
    t.wdata.tag = tag;
    t.wdata.data = {$random(seed), $random(seed)};
    t.be = be;
    t.tag = tag;
    t.flip = flip;
    t.gnt = gnt;
    t.cyc = cyc;
    t.hit = hit;
    t.err = err;
    tests.push_back(t);
  endtask

  task automatic build_tests();
    // full-line write, then hit and miss
    add_test(2'b01, 2'b01, 12'h010, 1, 1, 16'h1a5a, 11'h7ff, 0, 2'b01, 1, 2'b00, 2'b00);
    add_test(2'b01, 2'b11, 12'h010, 0, 0, 16'h1a5a, 11'h000, 0, 2'b01, 1, 2'b01, 2'b00);
    add_test(2'b01, 2'b11, 12'h010, 0, 0, 16'h1bbb, 11'h000, 0, 2'b01, 1, 2'b00, 2'b00);
    // both ports read, port 0 first
    add_test(2'b10, 2'b10, 12'h020, 1, 1, 16'h2c3c, 11'h7ff, 0, 2'b10, 1, 2'b00, 2'b00);
    add_test(2'b11, 2'b11, 12'h020, 0, 0, 16'h2c3c, 11'h000, 0, 2'b01, 2, 2'b10, 2'b00);
    // mixed enables in both blocks force a read-modify-write
    add_test(2'b10, 2'b10, 12'h020, 1, 0, 16'h0000, 11'h03c, 0, 2'b00, 2, 2'b00, 2'b00);
    add_test(2'b10, 2'b11, 12'h020, 0, 0, 16'h2c3c, 11'h000, 0, 2'b10, 1, 2'b10, 2'b00);
    // injected faults
    add_test(2'b01, 2'b01, 12'h030, 1, 1, 16'h1d1d, 11'h7ff, 0, 2'b01, 1, 2'b00, 2'b00);
    add_test(2'b01, 2'b11, 12'h030, 0, 0, 16'h1d1d, 11'h000, 1, 2'b01, 1, 2'b01, 2'b01);
    add_test(2'b01, 2'b01, 12'h040, 1, 1, 16'h1e1e, 11'h7ff, 0, 2'b01, 1, 2'b00, 2'b00);
    add_test(2'b01, 2'b11, 12'h040, 0, 0, 16'h1e1e, 11'h000, 2, 2'b01, 1, 2'b01, 2'b10);
    add_test(2'b01, 2'b01, 12'h050, 1, 1, 16'h1f0f, 11'h7ff, 0, 2'b01, 1, 2'b00, 2'b00);
    add_test(2'b01, 2'b11, 12'h050, 0, 0, 16'h1f0f, 11'h000, 3, 2'b01, 1, 2'b01, 2'b01);
    // line stored with valid low
    add_test(2'b10, 2'b10, 12'h060, 1, 0, 16'h2777, 11'h7ff, 0, 2'b10, 1, 2'b00, 2'b00);
    add_test(2'b10, 2'b11, 12'h060, 0, 0, 16'h2777, 11'h000, 0, 2'b10, 1, 2'b00, 2'b00);
  endtask

  // ------------------------------
  // test runner
  // ------------------------------
  task automatic run_test(input int idx);
    test_t              t;
    logic [1:0]         pend;
    int                 cyc;
    int                 errs;
    tag_cmp_pkg::line_t want;
    t = tests[idx];
    cyc = 0;
    errs = 0;
    @(posedge clk_i);
    #1;
    case (t.flip)
      2'd1: u_sram_model.flip_bit(0, t.addr, 5);
      2'd2: begin
        u_sram_model.flip_bit(0, t.addr, 5);
        u_sram_model.flip_bit(0, t.addr, 9);
      end
      2'd3: u_sram_model.flip_bit(0, t.addr, 80);
      default: ;
    endcase
    for (int p = 0; p < tag_cmp_pkg::NR_PORTS; p++) begin
      if (t.mask[p]) begin
        req_i[p] = t.req;
        addr_i[p] = t.addr;
        we_i[p] = t.we;
        wdata_i[p] = t.wdata;
        be_i[p] = t.be;
        tag_i[p] = t.tag;
      end else begin
        // an idle port shows a distant tag so a wrong tag select misses
        tag_i[p] = ~t.tag;
      end
    end
    // requesters hold until granted
    pend = t.mask;
    while (pend != 0) begin
      @(negedge clk_i);
      cyc++;
      if (cyc == 1) begin
        assert (gnt_o == t.gnt) else begin
          $display("mismatch gnt_o exp %h got %h", t.gnt, gnt_o);
          errs++;
        end
      end
      pend = pend & ~gnt_o;
      @(posedge clk_i);
      #1;
      for (int p = 0; p < tag_cmp_pkg::NR_PORTS; p++) begin
        if (!pend[p]) req_i[p] = '0;
      end
    end
    assert (cyc == t.cyc) else begin
      $display("requests took %0d cycles to be granted instead of %0d", cyc, t.cyc);
      errs++;
    end
    if (t.we) begin
      for (int w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin
        if (t.req[w]) begin
          ref_mem[w * (2**tag_cmp_pkg::ADDR_WIDTH) + t.addr] =
            merge_bytes(ref_read(w, t.addr), t.wdata, t.be);
        end
      end
    end else begin
      @(negedge clk_i);
      assert (hit_way_o == t.hit) else begin
        $display("mismatch hit_way_o exp %h got %h", t.hit, hit_way_o);
        errs++;
      end
      assert ({err_uncorrectable_o, err_correctable_o} == t.err) else begin
        $display("mismatch err_uncorrectable_o/err_correctable_o exp %h got %h",
                 t.err, {err_uncorrectable_o, err_correctable_o});
        errs++;
      end
      // data is not recoverable after a double flip
      if (!t.err[1]) begin
        for (int w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin
          want = ref_read(w, t.addr);
          assert (rdata_o[w] == want) else begin
            $display("mismatch rdata_o[%0d] exp %h got %h", w, want, rdata_o[w]);
            errs++;
          end
        end
      end
    end
    if (errs == 0) begin
      n_pass++;
      $display("test %0d ok", idx);
    end else begin
      n_fail++;
      $display("test %0d had %0d errors", idx, errs);
    end
  endtask

  // four cycles per entry leaves room for the two-cycle cases
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 4 * tests.size() + 3) begin
      $display("timeout after %0d cycles, a request was never granted", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    seed = 32'h6d75_6df8;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = '0;
    addr_i = '0;
    we_i = '0;
    wdata_i = '0;
    be_i = '0;
    tag_i = '0;
    build_tests();
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < tests.size(); i++) begin
      run_test(i);
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verif/sram_model.sv
// behavioral way memories cleared at time zero; read data arrives one cycle after a read request
`timescale 1ns/100ps

module sram_model (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic [tag_cmp_pkg::NR_WAYS-1:0]                   req_i,
  input  logic [tag_cmp_pkg::ADDR_WIDTH-1:0]                addr_i,
  input  logic                                              we_i,
  input  tag_cmp_pkg::line_ecc_t                            wdata_i,
  input  tag_cmp_pkg::sram_be_t                             be_i,
  output tag_cmp_pkg::line_ecc_t [tag_cmp_pkg::NR_WAYS-1:0] rdata_o
);

  tag_cmp_pkg::line_ecc_t mem [tag_cmp_pkg::NR_WAYS][2**tag_cmp_pkg::ADDR_WIDTH];

  initial begin
    for (int w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin
      for (int a = 0; a < 2**tag_cmp_pkg::ADDR_WIDTH; a++) begin
        mem[w][a] = '0;
      end
    end
  end

  // only the enabled code words change
  always @(posedge clk_i) begin
    for (int w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin
      if (req_i[w] && we_i) begin
        if (be_i.valid) mem[w][addr_i].valid <= wdata_i.valid;
        if (be_i.tag) mem[w][addr_i].tag <= wdata_i.tag;
        for (int b = 0; b < tag_cmp_pkg::NR_BLOCKS; b++) begin
          if (be_i.data[b]) begin
            mem[w][addr_i].data[b*tag_cmp_pkg::BLOCK_ECC_WIDTH +: tag_cmp_pkg::BLOCK_ECC_WIDTH] <=
              wdata_i.data[b*tag_cmp_pkg::BLOCK_ECC_WIDTH +: tag_cmp_pkg::BLOCK_ECC_WIDTH];
          end
        end
      end
    end
  end

  // read port holds its last value across writes and idle cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else begin
      for (int w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin
        if (req_i[w] && !we_i) rdata_o[w] <= mem[w][addr_i];
      end
    end
  end

  // fault injection on the stored encoded line
  task automatic flip_bit(input int way, input int addr, input int pos);
    logic [$bits(tag_cmp_pkg::line_ecc_t)-1:0] word;
    word = mem[way][addr];
    word[pos] = ~word[pos];
    mem[way][addr] = word;
  endtask

endmodule

//--- verilog/tag_cmp_top.sv
// requesters hold until granted; memory read data must arrive one cycle after the request
`timescale 1ns/100ps

module tag_cmp_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  // ------------------------------
  // requester side
  // ------------------------------
  input  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::NR_WAYS-1:0]    req_i,
  input  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [tag_cmp_pkg::NR_PORTS-1:0]                              we_i,
  input  tag_cmp_pkg::line_t [tag_cmp_pkg::NR_PORTS-1:0]                wdata_i,
  input  tag_cmp_pkg::be_t [tag_cmp_pkg::NR_PORTS-1:0]                  be_i,
  input  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::TAG_WIDTH-1:0]  tag_i,
  output logic [tag_cmp_pkg::NR_PORTS-1:0]                              gnt_o,
  output tag_cmp_pkg::line_t [tag_cmp_pkg::NR_WAYS-1:0]                 rdata_o,
  output logic [tag_cmp_pkg::NR_WAYS-1:0]                               hit_way_o,
  output logic                                                          err_correctable_o,
  output logic                                                          err_uncorrectable_o,
  // ------------------------------
  // memory side
  // ------------------------------
  output logic [tag_cmp_pkg::NR_WAYS-1:0]                               sram_req_o,
  output logic [tag_cmp_pkg::ADDR_WIDTH-1:0]                            sram_addr_o,
  output logic                                                          sram_we_o,
  output tag_cmp_pkg::line_ecc_t                                        sram_wdata_o,
  output tag_cmp_pkg::sram_be_t                                         sram_be_o,
  input  tag_cmp_pkg::line_ecc_t [tag_cmp_pkg::NR_WAYS-1:0]             sram_rdata_i
);

  logic [tag_cmp_pkg::NR_PORTS-1:0] gnt_arb;
  logic [tag_cmp_pkg::NR_PORTS-1:0] gnt_rmw;

  cache_req_if u_req_if ();
  rmw_if       u_rmw_if ();

  // live grants and the store-cycle grant never overlap
  assign gnt_o = gnt_arb | gnt_rmw;

  req_arbiter u_req_arbiter (
    .req_i   (req_i),
    .addr_i  (addr_i),
    .we_i    (we_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .gnt_o   (gnt_arb),
    .req     (u_req_if),
    .rmw     (u_rmw_if)
  );

  rmw_buffer u_rmw_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req         (u_req_if),
    .rmw         (u_rmw_if),
    .gnt_o       (gnt_rmw),
    .sram_req_o  (sram_req_o),
    .sram_addr_o (sram_addr_o),
    .sram_we_o   (sram_we_o),
    .sram_be_o   (sram_be_o)
  );

  line_merge u_line_merge (
    .rdata_i             (sram_rdata_i),
    .wdata_i             (u_req_if.wdata),
    .rmw                 (u_rmw_if),
    .rdata_o             (rdata_o),
    .sram_wdata_o        (sram_wdata_o),
    .err_correctable_o   (err_correctable_o),
    .err_uncorrectable_o (err_uncorrectable_o)
  );

  tag_match u_tag_match (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tag_i     (tag_i),
    .rmw       (u_rmw_if),
    .rdata_i   (sram_rdata_i),
    .hit_way_o (hit_way_o)
  );

endmodule

//--- verilog/tag_match.sv
// tag_i is sampled one cycle after the request; a one-bit tag fault still counts as a hit
`timescale 1ns/100ps

module tag_match (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::TAG_WIDTH-1:0] tag_i,
  rmw_if.user                                                       rmw,
  input  tag_cmp_pkg::line_ecc_t [tag_cmp_pkg::NR_WAYS-1:0]         rdata_i,
  output logic [tag_cmp_pkg::NR_WAYS-1:0]                           hit_way_o
);

  logic [tag_cmp_pkg::TAG_WIDTH-1:0]     sel_tag;
  logic [tag_cmp_pkg::TAG_ECC_WIDTH-1:0] sel_code;

  // registered one-hot id picks the port whose request was taken
  always_comb begin : tag_sel
    sel_tag = '0;
    for (int unsigned p = 0; p < tag_cmp_pkg::NR_PORTS; p++) begin
      if (rmw.id[p]) begin
        sel_tag = tag_i[p];
      end
    end
  end

  secded_codec #(.DataWidth(tag_cmp_pkg::TAG_WIDTH)) u_tag_enc (
    .data_i (sel_tag),
    .code_o (sel_code),
    .code_i ('0),
    .data_o (),
    .err_o  ()
  );

  // compare in the code domain, distance of one or less
  for (genvar w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin : g_cmp
    assign hit_way_o[w] = rdata_i[w].valid && ($countones(sel_code ^ rdata_i[w].tag) <= 1);
  end

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |rmw.req |-> $onehot0(hit_way_o))
    else $error("tag_match: hit on more than one way %b", hit_way_o);

endmodule

//--- verilog/line_merge.sv
// errors count only on valid ways; the merge takes the lowest requested way as the old line
`timescale 1ns/100ps

module line_merge (
  input  tag_cmp_pkg::line_ecc_t [tag_cmp_pkg::NR_WAYS-1:0] rdata_i,
  input  tag_cmp_pkg::line_t                                wdata_i,
  rmw_if.user                                               rmw,
  output tag_cmp_pkg::line_t [tag_cmp_pkg::NR_WAYS-1:0]     rdata_o,
  output tag_cmp_pkg::line_ecc_t                            sram_wdata_o,
  output logic                                              err_correctable_o,
  output logic                                              err_uncorrectable_o
);

  logic [tag_cmp_pkg::NR_WAYS-1:0][1:0]                           err_tag;
  logic [tag_cmp_pkg::NR_WAYS-1:0][tag_cmp_pkg::NR_BLOCKS-1:0][1:0] err_blk;
  tag_cmp_pkg::line_t                   sel_line;
  tag_cmp_pkg::line_t                   to_store;
  logic [tag_cmp_pkg::LINE_WIDTH-1:0]   data_mask;
  logic [tag_cmp_pkg::TAG_WIDTH-1:0]    tag_mask;

  // ------------------------------
  // read decode per way
  // ------------------------------
  for (genvar w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin : g_way
    assign rdata_o[w].valid = rdata_i[w].valid;

    secded_codec #(.DataWidth(tag_cmp_pkg::TAG_WIDTH)) u_tag_dec (
      .data_i ('0),
      .code_o (),
      .code_i (rdata_i[w].tag),
      .data_o (rdata_o[w].tag),
      .err_o  (err_tag[w])
    );

    for (genvar b = 0; b < tag_cmp_pkg::NR_BLOCKS; b++) begin : g_blk
      secded_codec #(.DataWidth(tag_cmp_pkg::BLOCK_WIDTH)) u_blk_dec (
        .data_i ('0),
        .code_o (),
        .code_i (rdata_i[w].data[b*tag_cmp_pkg::BLOCK_ECC_WIDTH +: tag_cmp_pkg::BLOCK_ECC_WIDTH]),
        .data_o (rdata_o[w].data[b*tag_cmp_pkg::BLOCK_WIDTH +: tag_cmp_pkg::BLOCK_WIDTH]),
        .err_o  (err_blk[w][b])
      );
    end
  end

  always_comb begin : err_flags
    err_correctable_o   = 1'b0;
    err_uncorrectable_o = 1'b0;
    for (int unsigned w = 0; w < tag_cmp_pkg::NR_WAYS; w++) begin
      if (rdata_i[w].valid) begin
        err_correctable_o   = err_correctable_o | err_tag[w][0];
        err_uncorrectable_o = err_uncorrectable_o | err_tag[w][1];
        for (int unsigned b = 0; b < tag_cmp_pkg::NR_BLOCKS; b++) begin
          err_correctable_o   = err_correctable_o | err_blk[w][b][0];
          err_uncorrectable_o = err_uncorrectable_o | err_blk[w][b][1];
        end
      end
    end
  end

  // ------------------------------
  // byte merge
  // ------------------------------
  always_comb begin : merge
    sel_line = '0;
    for (int w = tag_cmp_pkg::NR_WAYS - 1; w >= 0; w--) begin
      if (rmw.req[w]) begin
        sel_line = rdata_o[w];
      end
    end
    for (int unsigned i = 0; i < tag_cmp_pkg::LINE_WIDTH / 8; i++) begin
      data_mask[i*8 +: 8] = {8{rmw.be.data[i]}};
    end
    for (int unsigned i = 0; i < tag_cmp_pkg::TAG_WIDTH / 8; i++) begin
      tag_mask[i*8 +: 8] = {8{rmw.be.tag[i]}};
    end
    if (rmw.rmw_active) begin
      to_store.valid = rmw.be.valid ? rmw.wdata.valid : sel_line.valid;
      to_store.tag   = (tag_mask & rmw.wdata.tag) | (~tag_mask & sel_line.tag);
      to_store.data  = (data_mask & rmw.wdata.data) | (~data_mask & sel_line.data);
    end else begin
      to_store = wdata_i;
    end
  end

  // write encode
  assign sram_wdata_o.valid = to_store.valid;

  secded_codec #(.DataWidth(tag_cmp_pkg::TAG_WIDTH)) u_tag_enc (
    .data_i (to_store.tag),
    .code_o (sram_wdata_o.tag),
    .code_i ('0),
    .data_o (),
    .err_o  ()
  );

  for (genvar b = 0; b < tag_cmp_pkg::NR_BLOCKS; b++) begin : g_enc
    secded_codec #(.DataWidth(tag_cmp_pkg::BLOCK_WIDTH)) u_blk_enc (
      .data_i (to_store.data[b*tag_cmp_pkg::BLOCK_WIDTH +: tag_cmp_pkg::BLOCK_WIDTH]),
      .code_o (sram_wdata_o.data[b*tag_cmp_pkg::BLOCK_ECC_WIDTH +: tag_cmp_pkg::BLOCK_ECC_WIDTH]),
      .code_i ('0),
      .data_o (),
      .err_o  ()
    );
  end

endmodule

//--- verilog/rmw_buffer.sv
// a partial write takes one read cycle then one store cycle; the buffer holds during the store
`timescale 1ns/100ps

module rmw_buffer (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  cache_req_if.buffer                            req,
  rmw_if.buffer                                  rmw,
  output logic [tag_cmp_pkg::NR_PORTS-1:0]       gnt_o,
  output logic [tag_cmp_pkg::NR_WAYS-1:0]        sram_req_o,
  output logic [tag_cmp_pkg::ADDR_WIDTH-1:0]     sram_addr_o,
  output logic                                   sram_we_o,
  output tag_cmp_pkg::sram_be_t                  sram_be_o
);

  typedef enum logic {NORMAL, LOAD_AND_STORE} store_state_e;

  store_state_e                     state_d, state_q;
  logic [tag_cmp_pkg::NR_WAYS-1:0]    req_q;
  logic [tag_cmp_pkg::ADDR_WIDTH-1:0] addr_q;
  tag_cmp_pkg::be_t                   be_q;
  tag_cmp_pkg::line_t                 wdata_q;
  logic [tag_cmp_pkg::NR_PORTS-1:0]   id_q;
  tag_cmp_pkg::be_t                   be_sel;

  // store lasts exactly one cycle
  assign state_d = (state_q == NORMAL && req.partial) ? LOAD_AND_STORE : NORMAL;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= NORMAL;
      req_q   <= '0;
      addr_q  <= '0;
      be_q    <= '0;
      wdata_q <= '0;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == NORMAL) begin
        req_q   <= req.req;
        addr_q  <= req.addr;
        be_q    <= req.be;
        wdata_q <= req.wdata;
        id_q    <= req.id;
      end
    end
  end

  // ------------------------------
  // memory request mux
  // ------------------------------
  always_comb begin : mem_mux
    if (state_q == LOAD_AND_STORE) begin
      sram_req_o  = req_q;
      sram_addr_o = addr_q;
      sram_we_o   = 1'b1;
      be_sel      = be_q;
      gnt_o       = id_q;
    end else begin
      // the read half of a partial write goes out as a plain read
      sram_req_o  = req.req;
      sram_addr_o = req.addr;
      sram_we_o   = req.we && !req.partial;
      be_sel      = req.be;
      gnt_o       = '0;
    end
  end

  // any enabled byte enables the whole code word
  always_comb begin : be_expand
    sram_be_o.valid = be_sel.valid;
    sram_be_o.tag   = |be_sel.tag;
    for (int unsigned b = 0; b < tag_cmp_pkg::NR_BLOCKS; b++) begin
      sram_be_o.data[b] = |be_sel.data[b*tag_cmp_pkg::BLOCK_BYTES +: tag_cmp_pkg::BLOCK_BYTES];
    end
  end

  assign rmw.rmw_active = (state_q == LOAD_AND_STORE);
  assign rmw.req        = req_q;
  assign rmw.be         = be_q;
  assign rmw.wdata      = wdata_q;
  assign rmw.id         = id_q;

  // the stored port holds its partial write until the store grants it
  a_store_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == LOAD_AND_STORE |->
      (req.id == id_q && req.partial) || (req.id != '0 && req.id < id_q))
    else $error("rmw_buffer: stored port dropped its write before the store");

endmodule

//--- verilog/req_arbiter.sv
// lowest index wins; grant withheld while a partial write needs its read cycle or a store runs
`timescale 1ns/100ps

module req_arbiter (
  input  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::NR_WAYS-1:0]    req_i,
  input  logic [tag_cmp_pkg::NR_PORTS-1:0][tag_cmp_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [tag_cmp_pkg::NR_PORTS-1:0]                              we_i,
  input  tag_cmp_pkg::line_t [tag_cmp_pkg::NR_PORTS-1:0]                wdata_i,
  input  tag_cmp_pkg::be_t [tag_cmp_pkg::NR_PORTS-1:0]                  be_i,
  output logic [tag_cmp_pkg::NR_PORTS-1:0]                              gnt_o,
  cache_req_if.arb                                                      req,
  rmw_if.user                                                           rmw
);

  logic [tag_cmp_pkg::NR_PORTS-1:0] partial;
  logic [tag_cmp_pkg::NR_PORTS-1:0] port_req;

  // a block with mixed enables cannot be encoded without the old data
  always_comb begin : partial_detect
    for (int unsigned p = 0; p < tag_cmp_pkg::NR_PORTS; p++) begin
      partial[p] = 1'b0;
      for (int unsigned b = 0; b < tag_cmp_pkg::NR_BLOCKS; b++) begin
        if (we_i[p] &&
            be_i[p].data[b*tag_cmp_pkg::BLOCK_BYTES +: tag_cmp_pkg::BLOCK_BYTES] != '0 &&
            be_i[p].data[b*tag_cmp_pkg::BLOCK_BYTES +: tag_cmp_pkg::BLOCK_BYTES] != '1) begin
          partial[p] = 1'b1;
        end
      end
    end
  end

  // any way bit counts as a request of that port
  always_comb begin : port_req_or
    for (int unsigned p = 0; p < tag_cmp_pkg::NR_PORTS; p++) begin
      port_req[p] = |req_i[p];
    end
  end

  // ------------------------------
  // priority select
  // ------------------------------
  always_comb begin : select
    req.req     = '0;
    req.addr    = '0;
    req.we      = 1'b0;
    req.wdata   = '0;
    req.be      = '0;
    req.id      = '0;
    req.partial = 1'b0;
    // walk downwards so the lowest requesting index is left standing
    for (int i = tag_cmp_pkg::NR_PORTS - 1; i >= 0; i--) begin
      if (|req_i[i]) begin
        req.req     = req_i[i];
        req.addr    = addr_i[i];
        req.we      = we_i[i];
        req.wdata   = wdata_i[i];
        req.be      = be_i[i];
        req.id      = tag_cmp_pkg::NR_PORTS'(1) << i;
        req.partial = partial[i];
      end
    end
    gnt_o = req.id & {tag_cmp_pkg::NR_PORTS{!req.partial && !rmw.rmw_active}};
  end

  // a granted port requests and no lower port does
  a_gnt_lowest: assert final ($onehot0(gnt_o) && (gnt_o & ~port_req) == '0 &&
                             (gnt_o == '0 || ((gnt_o - 1'b1) & port_req) == '0))
    else $error("req_arbiter: grant %b not the lowest request %b", gnt_o, port_req);

endmodule

//--- verilog/secded_codec.sv
// corrects one flipped bit and flags two; wider faults may alias to a single-bit correction
`timescale 1ns/100ps

module secded_codec #(
  parameter int unsigned  DataWidth = 32,
  localparam int unsigned ParWidth  = $clog2(DataWidth + $clog2(DataWidth) + 1),
  localparam int unsigned HamWidth  = DataWidth + ParWidth,
  localparam int unsigned CodeWidth = HamWidth + 1
) (
  input  logic [DataWidth-1:0] data_i,
  output logic [CodeWidth-1:0] code_o,
  input  logic [CodeWidth-1:0] code_i,
  output logic [DataWidth-1:0] data_o,
  output logic [1:0]           err_o
);

  // bit 0 holds overall parity, powers of two hold the Hamming checks
  logic [HamWidth:0]   enc_cw;
  logic [HamWidth:0]   dec_cw;
  logic [ParWidth-1:0] syndrome;
  logic                parity;

  // ------------------------------
  // encoder
  // ------------------------------
  always_comb begin : encode
    int unsigned k;
    enc_cw = '0;
    k      = 0;
    for (int unsigned p = 1; p <= HamWidth; p++) begin
      if ((p & (p - 1)) != 0) begin
        enc_cw[p] = data_i[k];
        k++;
      end
    end
    for (int unsigned i = 0; i < ParWidth; i++) begin
      for (int unsigned p = 1; p <= HamWidth; p++) begin
        if (((p >> i) & 1) == 1 && (p & (p - 1)) != 0) begin
          enc_cw[1 << i] = enc_cw[1 << i] ^ enc_cw[p];
        end
      end
    end
    enc_cw[0] = ^enc_cw;
  end

  assign code_o = enc_cw;

  // ------------------------------
  // decoder
  // ------------------------------
  always_comb begin : decode
    int unsigned k;
    syndrome = '0;
    for (int unsigned p = 1; p <= HamWidth; p++) begin
      if (code_i[p]) begin
        syndrome = syndrome ^ ParWidth'(p);
      end
    end
    parity = ^code_i;
    dec_cw = code_i;
    // odd parity with a syndrome in range is a single flip at that position
    if (parity && syndrome != '0 && syndrome <= HamWidth) begin
      dec_cw[syndrome] = ~dec_cw[syndrome];
    end
    k = 0;
    for (int unsigned p = 1; p <= HamWidth; p++) begin
      if ((p & (p - 1)) != 0) begin
        data_o[k] = dec_cw[p];
        k++;
      end
    end
  end

  assign err_o[0] = parity && (syndrome <= HamWidth);
  assign err_o[1] = (!parity && syndrome != '0) || (parity && syndrome > HamWidth);

endmodule

//--- verilog/rmw_if.sv
// registered request state; only meaningful one cycle after the request was taken
`timescale 1ns/100ps

interface rmw_if;

  // high during the store half of a read-modify-write
  logic                             rmw_active;
  logic [tag_cmp_pkg::NR_WAYS-1:0]  req;
  tag_cmp_pkg::be_t                 be;
  tag_cmp_pkg::line_t               wdata;
  logic [tag_cmp_pkg::NR_PORTS-1:0] id;

  modport buffer (
    output rmw_active, req, be, wdata, id
  );

  modport user (
    input rmw_active, req, be, wdata, id
  );

endinterface

//--- verilog/cache_req_if.sv
// plain levels valid in the cycle they are driven; no handshake of its own
`timescale 1ns/100ps

interface cache_req_if;

  logic [tag_cmp_pkg::NR_WAYS-1:0]    req;
  logic [tag_cmp_pkg::ADDR_WIDTH-1:0] addr;
  logic                               we;
  tag_cmp_pkg::line_t                 wdata;
  tag_cmp_pkg::be_t                   be;
  // one-hot id of the winning port
  logic [tag_cmp_pkg::NR_PORTS-1:0]   id;
  // write with a block that is neither fully enabled nor fully masked
  logic                               partial;

  modport arb (
    output req, addr, we, wdata, be, id, partial
  );

  modport buffer (
    input req, addr, we, wdata, be, id, partial
  );

endinterface

//--- verilog/tag_cmp_pkg.sv
// geometry is fixed at 2 ports, 2 ways, 16-bit tag and 64-bit line; encoded widths match secded_codec
package tag_cmp_pkg;

  // ------------------------------
  // geometry
  // ------------------------------
  localparam int unsigned NR_PORTS   = 2;
  localparam int unsigned NR_WAYS    = 2;
  localparam int unsigned ADDR_WIDTH = 12;
  localparam int unsigned TAG_WIDTH  = 16;

  localparam int unsigned BLOCK_WIDTH = 32;
  localparam int unsigned NR_BLOCKS   = 2;
  localparam int unsigned LINE_WIDTH  = NR_BLOCKS * BLOCK_WIDTH;
  localparam int unsigned BLOCK_BYTES = BLOCK_WIDTH / 8;

  // ------------------------------
  // encoded widths
  // ------------------------------
  // extended Hamming: 5 + 1 check bits on the tag, 6 + 1 per data block
  localparam int unsigned TAG_ECC_WIDTH   = 22;
  localparam int unsigned BLOCK_ECC_WIDTH = 39;
  localparam int unsigned LINE_ECC_WIDTH  = NR_BLOCKS * BLOCK_ECC_WIDTH;

  // plain line as seen by the requesters
  typedef struct packed {
    logic                  valid;
    logic [TAG_WIDTH-1:0]  tag;
    logic [LINE_WIDTH-1:0] data;
  } line_t;

  // line as stored in the way memories, valid stays unprotected
  typedef struct packed {
    logic                      valid;
    logic [TAG_ECC_WIDTH-1:0]  tag;
    logic [LINE_ECC_WIDTH-1:0] data;
  } line_ecc_t;

  // requester byte enables
  typedef struct packed {
    logic                    valid;
    logic [TAG_WIDTH/8-1:0]  tag;
    logic [LINE_WIDTH/8-1:0] data;
  } be_t;

  // memory enables, one per code word
  typedef struct packed {
    logic                 valid;
    logic                 tag;
    logic [NR_BLOCKS-1:0] data;
  } sram_be_t;

endpackage
